// File: Makefile
SOURCES := $(wildcard source/*.sv sim/*.sv sim/*.svh)

.PHONY: all run check clean

all: check

obj_dir/Vtb_counter_timer: verilog.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/10ps -f verilog.f \
		--top-module tb_counter_timer -Mdir obj_dir -o Vtb_counter_timer

run: obj_dir/Vtb_counter_timer
	./obj_dir/Vtb_counter_timer | tee sim.log

check: run
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/tb_timer_model.svh
//##########################################################################
// Counter-timer reference model
// Expected register readback and expected one-shot end values
//##########################################################################
`ifndef TB_TIMER_MODEL_SVH
`define TB_TIMER_MODEL_SVH

// Enabled byte lanes come from the new word, the rest keep the old one
function automatic word_t expect_lanes(input word_t old_word, input word_t new_word,
                                       input be_t lanes);
    word_t mask;
    mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    return (old_word & ~mask) | (new_word & mask);
endfunction

// Config lives in lane 0, fields from bit 0 up
function automatic timer_cfg_t cfg_readback(input timer_cfg_t old_cfg, input word_t data,
                                            input be_t lanes);
    timer_cfg_t cfg;
    cfg = old_cfg;
    if (lanes[0]) begin
        cfg.enable  = data[0];
        cfg.oneshot = data[1];
        cfg.updown  = data[2];
        cfg.chain   = data[3];
        cfg.irq_ena = data[4];
    end
    return cfg;
endfunction

// Up count stops at the limit, down count at zero
function automatic logic [63:0] oneshot_end(input logic count_up, input logic [63:0] limit);
    return count_up ? limit : 64'd0;
endfunction

`endif

// File: sim/tb_counter_timer.sv
//##########################################################################
// Counter-timer testbench
// Register readback, one-shot, continuous and chained 64-bit counting
//##########################################################################
`timescale 1ns/10ps

module tb_counter_timer import timer_pkg::*; ();

    localparam logic [31:0] BASE_ADR       = 32'h2400_0000;
    localparam logic [31:0] SEED           = 32'h3046_f120;
    localparam int          TIMEOUT_CYCLES = 4000;  // 512-cycle one-shot times the tests, plus margin

    logic  clkin;
    logic  resetn;
    word_t wb_adr_i;
    word_t wb_dat_i;
    be_t   wb_sel_i;
    logic  wb_we_i;
    logic  wb_cyc_i;
    logic  wb_stb_i;
    logic  wb_ack_o;
    word_t wb_dat_o;
    logic  irq_o;

    int          mismatches;
    int          bus_errors;
    int          cycle_count;
    word_t       rd;
    word_t       wd;
    word_t       limit;
    be_t         lanes;
    timer_cfg_t  cfg;
    logic [63:0] exp_end;
    word_t       exp_val [2];
    word_t       exp_dat [2];
    timer_cfg_t  exp_cfg [2];

`include "tb_timer_model.svh"

    counter_timer_top #(
        .BASE_ADR (BASE_ADR)
    ) UUT (
        .clkin    (clkin),
        .resetn   (resetn),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_we_i  (wb_we_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o),
        .irq_o    (irq_o)
    );

    initial begin
        clkin = 1'b0;
        forever #10 clkin = ~clkin;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clkin);
            cycle_count++;
        end
        $display("timeout: run did not end within %0d cycles, %0d mismatches, %0d bus errors",
                 TIMEOUT_CYCLES, mismatches, bus_errors);
        $display("tests failed");
        $finish;
    end

    function automatic word_t reg_addr(input logic hi, input logic [7:0] ofs);
        return BASE_ADR | (hi ? {24'd0, HIGH_OFS} : 32'd0) | {24'd0, ofs};
    endfunction

    // One access, driven at the falling edge and sampled mid low phase
    task automatic bus_access(input logic we, input word_t adr, input word_t data,
                              input be_t sel, output word_t rdata, output logic ack);
        @(negedge clkin);
        wb_adr_i = adr;
        wb_dat_i = data;
        wb_sel_i = sel;
        wb_we_i  = we;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        #5;
        ack   = wb_ack_o;  // Same-cycle ack
        rdata = wb_dat_o;
        @(negedge clkin);
        wb_we_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic bus_write(input word_t adr, input word_t data, input be_t sel);
        word_t unused;
        logic  ack;
        bus_access(1'b1, adr, data, sel, unused, ack);
        if (!ack) begin
            $display("error at %0t: write to %h got no acknowledge", $time, adr);
            bus_errors++;
        end
    endtask

    task automatic bus_read(input word_t adr, output word_t data);
        logic ack;
        bus_access(1'b0, adr, 32'd0, 4'hf, data, ack);
        if (!ack) begin
            $display("error at %0t: read from %h got no acknowledge", $time, adr);
            bus_errors++;
        end
    endtask

    task automatic check_unmapped(input word_t adr);
        word_t unused;
        logic  ack;
        bus_access(1'b0, adr, 32'd0, 4'hf, unused, ack);
        if (ack) begin
            $display("error at %0t: unmapped address %h was acknowledged", $time, adr);
            bus_errors++;
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_cfg(input timer_cfg_t got, input timer_cfg_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // Counter has stopped once two reads in a row agree
    task automatic poll_until_stopped(input word_t adr, output word_t final_val);
        word_t prev;
        word_t cur;
        bus_read(adr, prev);
        bus_read(adr, cur);
        while (cur !== prev) begin
            prev = cur;
            bus_read(adr, cur);
        end
        final_val = cur;
    endtask

    initial begin
        resetn     = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        wb_sel_i   = '0;
        wb_we_i    = 1'b0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        mismatches = 0;
        bus_errors = 0;
        void'($urandom(SEED));
        repeat (10) @(posedge clkin);
        @(negedge clkin);
        resetn = 1'b1;

        // Reset state
        for (int c = 0; c < 2; c++) begin
            exp_val[c] = '0;
            exp_dat[c] = '0;
            exp_cfg[c] = '0;
            bus_read(reg_addr(c[0], CFG_OFS), rd);
            check_word(rd, 32'd0, $sformatf("counter %0d config after reset", c));
            bus_read(reg_addr(c[0], VAL_OFS), rd);
            check_word(rd, 32'd0, $sformatf("counter %0d limit after reset", c));
            bus_read(reg_addr(c[0], DAT_OFS), rd);
            check_word(rd, 32'd0, $sformatf("counter %0d value after reset", c));
        end
        check_word({31'd0, irq_o}, 32'd0, "irq after reset");

        // Byte-lane readback of limit and value, counters idle
        for (int n = 0; n < 8; n++) begin
            for (int c = 0; c < 2; c++) begin
                wd    = $urandom;
                lanes = 4'($urandom);
                bus_write(reg_addr(c[0], VAL_OFS), wd, lanes);
                exp_val[c] = expect_lanes(exp_val[c], wd, lanes);
                bus_read(reg_addr(c[0], VAL_OFS), rd);
                check_word(rd, exp_val[c], $sformatf("counter %0d limit readback", c));
                wd    = $urandom;
                lanes = 4'($urandom);
                bus_write(reg_addr(c[0], DAT_OFS), wd, lanes);
                exp_dat[c] = expect_lanes(exp_dat[c], wd, lanes);
                bus_read(reg_addr(c[0], DAT_OFS), rd);
                check_word(rd, exp_dat[c], $sformatf("counter %0d value readback", c));
            end
        end

        // Config readback, 5 bits zero-extended
        for (int n = 0; n < 6; n++) begin
            for (int c = 0; c < 2; c++) begin
                wd    = $urandom;
                lanes = 4'($urandom);
                bus_write(reg_addr(c[0], CFG_OFS), wd, lanes);
                exp_cfg[c] = cfg_readback(exp_cfg[c], wd, lanes);
                bus_read(reg_addr(c[0], CFG_OFS), rd);
                check_cfg(timer_cfg_t'(rd[CFG_WIDTH-1:0]), exp_cfg[c],
                          $sformatf("counter %0d config readback", c));
                check_word(rd >> CFG_WIDTH, 32'd0, $sformatf("counter %0d config upper bits", c));
            end
        end
        bus_write(reg_addr(1'b0, CFG_OFS), 32'd0, 4'h1);
        bus_write(reg_addr(1'b1, CFG_OFS), 32'd0, 4'h1);
        check_unmapped(BASE_ADR | 32'h0000_000c);
        check_unmapped(BASE_ADR | 32'h0000_001c);
        check_unmapped(BASE_ADR ^ 32'h0100_0000);

        // One-shot down count on the low word
        limit = ($urandom % 255) + 1;
        bus_write(reg_addr(1'b0, VAL_OFS), limit, 4'hf);
        cfg = '{irq_ena: 1'b1, chain: 1'b0, updown: 1'b0, oneshot: 1'b1, enable: 1'b1};
        bus_write(reg_addr(1'b0, CFG_OFS), word_t'(cfg), 4'h1);
        poll_until_stopped(reg_addr(1'b0, DAT_OFS), rd);
        exp_end = oneshot_end(1'b0, {32'd0, limit});
        check_word(rd, exp_end[31:0], "low one-shot down end value");
        check_word({31'd0, irq_o}, 32'd1, "irq after low one-shot");
        bus_write(reg_addr(1'b0, CFG_OFS), 32'd0, 4'h1);

        // One-shot up count on the high word
        limit = ($urandom % 255) + 1;
        bus_write(reg_addr(1'b1, VAL_OFS), limit, 4'hf);
        cfg = '{irq_ena: 1'b1, chain: 1'b0, updown: 1'b1, oneshot: 1'b1, enable: 1'b1};
        bus_write(reg_addr(1'b1, CFG_OFS), word_t'(cfg), 4'h1);
        poll_until_stopped(reg_addr(1'b1, DAT_OFS), rd);
        exp_end = oneshot_end(1'b1, {32'd0, limit});
        check_word(rd, exp_end[31:0], "high one-shot up end value");
        check_word({31'd0, irq_o}, 32'd1, "irq after high one-shot");
        bus_write(reg_addr(1'b1, CFG_OFS), 32'd0, 4'h1);

        // Continuous down count, short limit so it reloads often
        limit = ($urandom % 32) + 4;
        bus_write(reg_addr(1'b0, VAL_OFS), limit, 4'hf);
        cfg = '{irq_ena: 1'b0, chain: 1'b0, updown: 1'b0, oneshot: 1'b0, enable: 1'b1};
        bus_write(reg_addr(1'b0, CFG_OFS), word_t'(cfg), 4'h1);
        for (int n = 0; n < 40; n++) begin
            bus_read(reg_addr(1'b0, DAT_OFS), rd);
            if (rd > limit) begin
                $display("mismatch at %0t: continuous sample %h above limit %h", $time, rd, limit);
                mismatches++;
            end
            check_word({31'd0, irq_o}, 32'd0, "irq in continuous mode with irq_ena clear");
        end
        bus_write(reg_addr(1'b0, CFG_OFS), 32'd0, 4'h1);

        // Chained 64-bit one-shot up count
        bus_write(reg_addr(1'b0, VAL_OFS), 32'd15, 4'hf);
        bus_write(reg_addr(1'b1, VAL_OFS), 32'd2, 4'hf);
        cfg = '{irq_ena: 1'b0, chain: 1'b1, updown: 1'b1, oneshot: 1'b1, enable: 1'b1};
        bus_write(reg_addr(1'b1, CFG_OFS), word_t'(cfg), 4'h1);
        bus_write(reg_addr(1'b0, CFG_OFS), word_t'(cfg), 4'h1);  // Both words start here
        bus_write(reg_addr(1'b1, DAT_OFS), 32'd1, 4'hf);        // One step short of the high limit
        bus_write(reg_addr(1'b0, DAT_OFS), 32'hffff_fff0, 4'hf);
        poll_until_stopped(reg_addr(1'b0, DAT_OFS), rd);
        bus_read(reg_addr(1'b1, DAT_OFS), wd);
        exp_end = oneshot_end(1'b1, {32'd2, 32'd15});
        check_word(wd, exp_end[63:32], "chained high word end value");
        check_word(rd, exp_end[31:0], "chained low word end value");

        $display("summary: %0d mismatches, %0d bus errors", mismatches, bus_errors);
        if (mismatches == 0 && bus_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: source/counter_timer_high.sv
//##########################################################################
// High-word counter-timer
// 32-bit up/down timer, on its own or as the high half of a 64-bit
// count that steps on the low-word strobe
//##########################################################################
`timescale 1ns/10ps

module counter_timer_high import timer_pkg::*; (
    input  logic         clkin,
    input  logic         resetn,
    timer_reg_if.ctr     regs,
    timer_chain_if.high  chain,
    output logic         irq_o
);

    timer_cfg_t cfg_q;
    word_t      limit_q;
    word_t      value_q;
    logic       last_enable_q;
    logic       stop_q;

    logic  loc_enable;
    logic  start;
    logic  advance;
    word_t start_val;
    word_t end_val;
    word_t next_val;

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            cfg_q   <= '0;
            limit_q <= '0;
        end else begin
            if (regs.cfg_we) begin
                cfg_q.enable  <= regs.wdata[CFG_BIT_ENABLE];
                cfg_q.oneshot <= regs.wdata[CFG_BIT_ONESHOT];
                cfg_q.updown  <= regs.wdata[CFG_BIT_UPDOWN];
                cfg_q.chain   <= regs.wdata[CFG_BIT_CHAIN];
                cfg_q.irq_ena <= regs.wdata[CFG_BIT_IRQ_ENA];
            end
            if (regs.val_we != 4'b0000) limit_q <= merge_lanes(limit_q, regs.wdata, regs.val_we);
        end
    end

    assign regs.cfg_rdata = {{(32-CFG_WIDTH){1'b0}}, cfg_q};
    assign regs.val_rdata = limit_q;
    assign regs.dat_rdata = value_q;

    assign loc_enable = cfg_q.chain ? (cfg_q.enable && chain.low_enable) : cfg_q.enable;
    assign start      = loc_enable && !last_enable_q;
    assign advance    = !cfg_q.chain || chain.strobe;  // Chained, step once per low rollover

    assign start_val = cfg_q.updown ? 32'd0 : limit_q;
    assign end_val   = !cfg_q.updown ? 32'd0 :
                       (cfg_q.chain && chain.is_offset) ? limit_q - 32'd1 : limit_q;
    assign next_val  = cfg_q.updown ? value_q + 32'd1 : value_q - 32'd1;

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            value_q       <= '0;
            last_enable_q <= 1'b0;
            stop_q        <= 1'b0;
        end else begin
            last_enable_q <= loc_enable;
            if (regs.dat_we != 4'b0000) begin
                value_q <= merge_lanes(value_q, regs.wdata, regs.dat_we);
            end else if (start) begin
                value_q <= start_val;  // Load even without a strobe
                stop_q  <= 1'b0;
            end else if (loc_enable && advance) begin
                if (value_q == end_val) begin
                    if (cfg_q.oneshot) begin
                        stop_q <= 1'b1;
                    end else begin
                        value_q <= start_val;
                        stop_q  <= 1'b0;
                    end
                end else begin
                    value_q <= next_val;
                    stop_q  <= (next_val == end_val);
                end
            end
        end
    end

    assign chain.high_enable = cfg_q.enable;
    assign chain.high_stop   = stop_q;  // Lets the low word stop

    assign irq_o = stop_q && cfg_q.irq_ena;

    // Chained, only the low strobe moves the high word once running
    a_hold_no_strobe: assert property (@(posedge clkin) disable iff (!resetn)
        cfg_q.chain && !chain.strobe && regs.dat_we == 4'b0000 && !start
        |=> $stable(value_q))
        else $error("counter_timer_high: value moved without strobe");

endmodule

// File: source/counter_timer_low.sv
//##########################################################################
// Low-word counter-timer
// 32-bit up/down timer, one-shot or continuous, and the low half of a
// chained 64-bit count with an early rollover strobe to the high word
//##########################################################################
`timescale 1ns/10ps

module counter_timer_low import timer_pkg::*; (
    input  logic        clkin,
    input  logic        resetn,
    timer_reg_if.ctr    regs,
    timer_chain_if.low  chain,
    output logic        irq_o
);

    timer_cfg_t cfg_q;
    word_t      limit_q;         // Reload / stop value
    word_t      value_q;
    logic       last_enable_q;   // For the enable rising edge
    logic       strobe_q;
    logic       stop_q;

    logic  loc_enable;
    logic  start;
    logic  stop_ok;
    word_t start_val;
    word_t end_val;
    word_t next_val;
    word_t pre_roll;

    // Configuration and limit registers
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            cfg_q   <= '0;
            limit_q <= '0;
        end else begin
            if (regs.cfg_we) begin
                cfg_q.enable  <= regs.wdata[CFG_BIT_ENABLE];
                cfg_q.oneshot <= regs.wdata[CFG_BIT_ONESHOT];
                cfg_q.updown  <= regs.wdata[CFG_BIT_UPDOWN];
                cfg_q.chain   <= regs.wdata[CFG_BIT_CHAIN];
                cfg_q.irq_ena <= regs.wdata[CFG_BIT_IRQ_ENA];
            end
            if (regs.val_we != 4'b0000) limit_q <= merge_lanes(limit_q, regs.wdata, regs.val_we);
        end
    end

    assign regs.cfg_rdata = {{(32-CFG_WIDTH){1'b0}}, cfg_q};
    assign regs.val_rdata = limit_q;
    assign regs.dat_rdata = value_q;

    // Chained, both words must be enabled to run
    assign loc_enable = cfg_q.chain ? (cfg_q.enable && chain.high_enable) : cfg_q.enable;
    assign start      = loc_enable && !last_enable_q;

    // Chained, stop only once the high word has stopped too
    assign stop_ok = !cfg_q.chain || chain.high_stop;

    assign start_val = cfg_q.updown ? 32'd0 : limit_q;
    assign end_val   = cfg_q.updown ? limit_q : 32'd0;
    assign next_val  = cfg_q.updown ? value_q + 32'd1 : value_q - 32'd1;
    assign pre_roll  = cfg_q.updown ? 32'hffff_fffe : 32'd2;  // Strobe ahead of rollover

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            value_q       <= '0;
            last_enable_q <= 1'b0;
            strobe_q      <= 1'b0;
            stop_q        <= 1'b0;
        end else begin
            last_enable_q <= loc_enable;
            strobe_q      <= 1'b0;
            if (regs.dat_we != 4'b0000) begin
                value_q <= merge_lanes(value_q, regs.wdata, regs.dat_we);
            end else if (start) begin
                value_q <= start_val;
                stop_q  <= 1'b0;
            end else if (loc_enable) begin
                if (cfg_q.chain) strobe_q <= (value_q == pre_roll);
                if (stop_ok && value_q == end_val) begin
                    if (cfg_q.oneshot) begin
                        stop_q <= 1'b1;  // Hold at end value
                    end else begin
                        value_q <= start_val;
                        stop_q  <= 1'b0;
                    end
                end else begin
                    value_q <= next_val;
                    stop_q  <= stop_ok && (next_val == end_val);
                end
            end
        end
    end

    assign chain.strobe     = strobe_q;
    assign chain.low_enable = cfg_q.enable;
    // Up count to 0 wraps with the high word, so the high word stops one early
    assign chain.is_offset  = cfg_q.updown && (limit_q == 32'd0);

    assign irq_o = stop_q && cfg_q.irq_ena;

    a_strobe_chain: assert property (@(posedge clkin) disable iff (!resetn)
        chain.strobe |-> $past(cfg_q.chain))
        else $error("counter_timer_low: strobe while not chained");

endmodule

// File: source/counter_timer_top.sv
//##########################################################################
// Counter-timer top level
// Bus block and two 32-bit counter-timers, chainable as one 64-bit count
//##########################################################################
`timescale 1ns/10ps

module counter_timer_top import timer_pkg::*; #(
    parameter logic [31:0] BASE_ADR = 32'h2400_0000
) (
    input  logic  clkin,
    input  logic  resetn,
    input  word_t wb_adr_i,
    input  word_t wb_dat_i,
    input  be_t   wb_sel_i,
    input  logic  wb_we_i,
    input  logic  wb_cyc_i,
    input  logic  wb_stb_i,
    output logic  wb_ack_o,
    output word_t wb_dat_o,
    output logic  irq_o
);

    logic lo_irq;
    logic hi_irq;

    timer_reg_if   lo_regs ();
    timer_reg_if   hi_regs ();
    timer_chain_if chain_if ();  // Low word to high word

    timer_bus #(
        .BASE_ADR (BASE_ADR)
    ) u_bus (
        .clkin    (clkin),
        .resetn   (resetn),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_we_i  (wb_we_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o),
        .lo_irq_i (lo_irq),
        .hi_irq_i (hi_irq),
        .irq_o    (irq_o),
        .lo_regs  (lo_regs),
        .hi_regs  (hi_regs)
    );

    counter_timer_low u_low (
        .clkin  (clkin),
        .resetn (resetn),
        .regs   (lo_regs),
        .chain  (chain_if),
        .irq_o  (lo_irq)
    );

    counter_timer_high u_high (
        .clkin  (clkin),
        .resetn (resetn),
        .regs   (hi_regs),
        .chain  (chain_if),
        .irq_o  (hi_irq)
    );

endmodule

// File: source/timer_bus.sv
//##########################################################################
// Counter-timer bus block
// Wishbone address decode, write enables, read mux, ack and irq combine
//##########################################################################
`timescale 1ns/10ps

module timer_bus import timer_pkg::*; #(
    parameter logic [31:0] BASE_ADR = 32'h2400_0000
) (
    input  logic         clkin,
    input  logic         resetn,
    input  word_t        wb_adr_i,
    input  word_t        wb_dat_i,
    input  be_t          wb_sel_i,
    input  logic         wb_we_i,
    input  logic         wb_cyc_i,
    input  logic         wb_stb_i,
    output logic         wb_ack_o,
    output word_t        wb_dat_o,
    input  logic         lo_irq_i,
    input  logic         hi_irq_i,
    output logic         irq_o,
    timer_reg_if.bus     lo_regs,
    timer_reg_if.bus     hi_regs
);

    logic       valid;
    logic [5:0] sel;     // lo cfg, val, dat then hi cfg, val, dat
    logic       irq_q;

    function automatic word_t reg_adr(input logic [7:0] ofs);
        return BASE_ADR | {24'd0, ofs};
    endfunction

    assign valid  = wb_cyc_i && wb_stb_i;
    assign sel[0] = valid && (wb_adr_i == reg_adr(CFG_OFS));
    assign sel[1] = valid && (wb_adr_i == reg_adr(VAL_OFS));
    assign sel[2] = valid && (wb_adr_i == reg_adr(DAT_OFS));
    assign sel[3] = valid && (wb_adr_i == reg_adr(HIGH_OFS | CFG_OFS));
    assign sel[4] = valid && (wb_adr_i == reg_adr(HIGH_OFS | VAL_OFS));
    assign sel[5] = valid && (wb_adr_i == reg_adr(HIGH_OFS | DAT_OFS));

    // Config is a single byte, so only lane 0 counts
    assign lo_regs.cfg_we = sel[0] && wb_we_i && wb_sel_i[0];
    assign lo_regs.val_we = sel[1] ? (wb_sel_i & {4{wb_we_i}}) : 4'b0000;
    assign lo_regs.dat_we = sel[2] ? (wb_sel_i & {4{wb_we_i}}) : 4'b0000;
    assign lo_regs.wdata  = wb_dat_i;
    assign hi_regs.cfg_we = sel[3] && wb_we_i && wb_sel_i[0];
    assign hi_regs.val_we = sel[4] ? (wb_sel_i & {4{wb_we_i}}) : 4'b0000;
    assign hi_regs.dat_we = sel[5] ? (wb_sel_i & {4{wb_we_i}}) : 4'b0000;
    assign hi_regs.wdata  = wb_dat_i;

    always_comb begin
        wb_dat_o = '0;
        if (sel[0])      wb_dat_o = lo_regs.cfg_rdata;
        else if (sel[1]) wb_dat_o = lo_regs.val_rdata;
        else if (sel[2]) wb_dat_o = lo_regs.dat_rdata;
        else if (sel[3]) wb_dat_o = hi_regs.cfg_rdata;
        else if (sel[4]) wb_dat_o = hi_regs.val_rdata;
        else if (sel[5]) wb_dat_o = hi_regs.dat_rdata;
    end

    assign wb_ack_o = |sel;  // No wait states

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) irq_q <= 1'b0;
        else         irq_q <= lo_irq_i || hi_irq_i;
    end

    assign irq_o = irq_q;

    a_sel_onehot: assert property (@(posedge clkin) disable iff (!resetn) $onehot0(sel))
        else $error("timer_bus: more than one register selected");
    a_ack_valid: assert property (@(posedge clkin) disable iff (!resetn)
        wb_ack_o |-> wb_cyc_i && wb_stb_i)
        else $error("timer_bus: ack without cyc and stb");

endmodule

// File: source/timer_ifs.sv
//##########################################################################
// Counter-timer interfaces
// Register access from the bus block and the low-to-high counter chain
//##########################################################################
`timescale 1ns/10ps

interface timer_reg_if import timer_pkg::*; ();

    logic  cfg_we;       // Lane 0 write of the config word
    be_t   val_we;       // Limit register lanes
    be_t   dat_we;       // Current value lanes
    word_t wdata;
    word_t cfg_rdata;
    word_t val_rdata;
    word_t dat_rdata;

    modport bus (
        output cfg_we, val_we, dat_we, wdata,
        input  cfg_rdata, val_rdata, dat_rdata
    );

    modport ctr (
        input  cfg_we, val_we, dat_we, wdata,
        output cfg_rdata, val_rdata, dat_rdata
    );

endinterface

interface timer_chain_if ();

    logic strobe;        // Low word about to roll over
    logic is_offset;     // Low word counts up to a limit of 0
    logic low_enable;
    logic high_enable;
    logic high_stop;     // High word has reached its end value

    modport low  (output strobe, is_offset, low_enable, input high_enable, high_stop);
    modport high (input strobe, is_offset, low_enable, output high_enable, high_stop);

endinterface

// File: source/timer_pkg.sv
//##########################################################################
// Counter-timer package
// Register offsets, configuration word layout and shared data types
//##########################################################################
package timer_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;

    // Register byte offsets within one counter block
    localparam logic [7:0] CFG_OFS  = 8'h00;
    localparam logic [7:0] VAL_OFS  = 8'h04;
    localparam logic [7:0] DAT_OFS  = 8'h08;
    localparam logic [7:0] HIGH_OFS = 8'h10;  // High counter block

    // Configuration word, bit 0 upwards
    localparam int CFG_WIDTH       = 5;
    localparam int CFG_BIT_ENABLE  = 0;
    localparam int CFG_BIT_ONESHOT = 1;
    localparam int CFG_BIT_UPDOWN  = 2;
    localparam int CFG_BIT_CHAIN   = 3;
    localparam int CFG_BIT_IRQ_ENA = 4;

    typedef struct packed {
        logic irq_ena;   // Interrupt on timeout
        logic chain;     // Pair with the other counter as a 64-bit count
        logic updown;    // 1 counts up, 0 counts down
        logic oneshot;   // 1 stops at end value, 0 reloads
        logic enable;
    } timer_cfg_t;

    // Byte-lane merge of a register write
    function automatic word_t merge_lanes(input word_t old_word, input word_t new_word,
                                          input be_t be);
        word_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) merged[8*i +: 8] = new_word[8*i +: 8];
        end
        return merged;
    endfunction

endpackage

// File: verilog.f
+incdir+sim
source/timer_pkg.sv
source/timer_ifs.sv
source/timer_bus.sv
source/counter_timer_low.sv
source/counter_timer_high.sv
source/counter_timer_top.sv
sim/tb_counter_timer.sv
